// File: src/cart_pkg.sv
// Shared widths, header addresses and types for the cartridge download pipeline; import where used
package cart_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Download stream
	////////////////////////////////////////////////////////////////////////////

	localparam int dl_addr_w = 25;        // Byte address
	localparam int dl_data_w = 16;

	typedef logic [dl_addr_w-1:0] dl_addr_t;
	typedef logic [dl_data_w-1:0] dl_data_t;

	// Even header word addresses
	localparam dl_addr_t addr_id_first = 25'h180;
	localparam dl_addr_t addr_id_last  = 25'h18A;  // Low byte only
	localparam dl_addr_t addr_region0  = 25'h1F0;
	localparam dl_addr_t addr_region1  = 25'h1F2;
	localparam dl_addr_t addr_hdr_done = 25'h200;

	////////////////////////////////////////////////////////////////////////////
	// Header record and results
	////////////////////////////////////////////////////////////////////////////

	// ROM bytes 0x183..0x18A with the first byte in the top bits
	typedef logic [63:0] cart_serial_t;

	typedef struct packed {
		logic j;
		logic u;
		logic e;
	} region_flags_t;

	typedef enum logic [1:0] {
		jp = 2'd0,
		us = 2'd1,
		eu = 2'd2
	} region_e;

	// Search orders whose first letter is also the fallback
	typedef enum logic [1:0] {
		prio_uej = 2'd0,
		prio_euj = 2'd1,
		prio_uje = 2'd2,
		prio_jue = 2'd3
	} prio_e;

	typedef logic [2:0] eeprom_map_t;

	localparam logic [7:0] gun_delay_default = 8'd44;  // Light gun sensor offset

endpackage

// File: src/hdr_if.sv
// Four-phase req/ack link that carries the captured header record from capture to classify
`timescale 1ns/10ps

interface hdr_if;
	import cart_pkg::*;

	logic          req;     // Record valid until ack
	logic          ack;
	cart_serial_t  serial;
	region_flags_t flags;   // Markets named in the header

	// Capture side
	modport src (
		output req,
		output serial,
		output flags,
		input  ack
	);

	// Classify side
	modport dst (
		input  req,
		input  serial,
		input  flags,
		output ack
	);

endinterface

// File: src/header_capture.sv
// First pipeline stage that collects the serial, region flags and ROM size from download writes
`timescale 1ns/10ps

module header_capture (
	input  logic               clk_sys,
	input  logic               RESET,
	input  logic               dl_active,
	input  logic               dl_wr,
	input  cart_pkg::dl_addr_t dl_addr,
	input  cart_pkg::dl_data_t dl_data,
	hdr_if.src                 hdr,
	output cart_pkg::dl_addr_t rom_size
);
	import cart_pkg::*;

	logic          dl_active_d;
	logic          hdr_wr;
	logic          done_pend;   // Header-done seen with req not yet raised
	dl_addr_t      id_off;
	logic [7:0]    lo_byte;     // Even address byte
	logic [7:0]    hi_byte;
	logic [3:0]    hex_val;
	region_flags_t lo_flags;
	region_flags_t flags;
	cart_serial_t  serial;

	// One-hot flag for a market letter and zero for anything else
	function automatic region_flags_t char_flag(input logic [7:0] c);
		region_flags_t f;
		f = '0;
		case (c)
			"J":     f.j = 1'b1;
			"U":     f.u = 1'b1;
			"E":     f.e = 1'b1;
			default: f = '0;
		endcase
		return f;
	endfunction

	assign hdr_wr  = dl_active & dl_wr;
	assign lo_byte = dl_data[7:0];
	assign hi_byte = dl_data[15:8];
	assign id_off  = dl_addr - addr_id_first;  // Wraps below the serial window
	assign hex_val = lo_byte[3:0] - 4'd7;       // 'A'..'F' -> 10..15

	// Low byte of the first region word as a letter or numeric code
	always_comb begin
		lo_flags = flags;
		if (char_flag(lo_byte) != '0)
			lo_flags = flags | char_flag(lo_byte);
		else if (lo_byte >= "0" && lo_byte <= "9")
			lo_flags = '{j: lo_byte[0], u: lo_byte[2], e: lo_byte[3]};
		else if (lo_byte >= "A" && lo_byte <= "F")
			lo_flags = '{j: hex_val[0], u: hex_val[2], e: hex_val[3]};
	end

	////////////////////////////////////////////////////////////////////////////
	// Control, flags and handshake
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_active_d <= 1'b0;
			flags       <= '0;
			done_pend   <= 1'b0;
			hdr.req     <= 1'b0;
			rom_size    <= '0;
		end else begin
			dl_active_d <= dl_active;
			if (dl_active && !dl_active_d)
				flags <= '0;                  // New download
			if (!dl_active && dl_active_d)
				rom_size <= dl_addr;          // Final address on the way out

			if (hdr.req && hdr.ack)
				hdr.req <= 1'b0;
			else if (done_pend && !hdr.req && !hdr.ack) begin
				hdr.req   <= 1'b1;
				done_pend <= 1'b0;
			end

			if (hdr_wr) begin
				if (dl_addr == addr_region0)
					flags <= lo_flags | char_flag(hi_byte);
				if (dl_addr == addr_region1)
					flags <= flags | char_flag(lo_byte);
				if (dl_addr == addr_hdr_done)
					done_pend <= 1'b1;
			end
		end
	end

	// Serial bytes arrive swapped within each word
	always_ff @(posedge clk_sys) begin
		if (hdr_wr && id_off <= addr_id_last - addr_id_first) begin
			case (id_off[3:0])
				4'h2:    serial[63:56] <= hi_byte;  // Byte 0x183
				4'h4:    serial[55:40] <= {lo_byte, hi_byte};
				4'h6:    serial[39:24] <= {lo_byte, hi_byte};
				4'h8:    serial[23:8]  <= {lo_byte, hi_byte};
				4'hA:    serial[7:0]   <= lo_byte;
				default: serial        <= serial;
			endcase
		end
	end

	assign hdr.serial = serial;
	assign hdr.flags  = flags;

endmodule

// File: src/cart_classify.sv
// Second pipeline stage that matches the serial against the quirk table and passes the flags on
`timescale 1ns/10ps

module cart_classify (
	input  logic                    clk_sys,
	input  logic                    RESET,
	hdr_if.dst                      hdr,
	output logic                    rgn_req,
	input  logic                    rgn_ack,
	output cart_pkg::region_flags_t rgn_flags,
	output cart_pkg::eeprom_map_t   eeprom_map,
	output logic                    bank_eeprom_quirk,
	output logic                    fmbusy_quirk,
	output logic                    gun_type,
	output logic [7:0]              gun_sensor_delay
);
	import cart_pkg::*;

	logic accept;

	// Region link must be fully idle before a new record goes in
	assign accept = hdr.req && !hdr.ack && !rgn_req && !rgn_ack;

	////////////////////////////////////////////////////////////////////////////
	// Handshakes and quirk table
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr.ack           <= 1'b0;
			rgn_req           <= 1'b0;
			eeprom_map        <= '0;
			bank_eeprom_quirk <= 1'b0;
			fmbusy_quirk      <= 1'b0;
			gun_type          <= 1'b0;
			gun_sensor_delay  <= gun_delay_default;
		end else begin
			if (!hdr.req && hdr.ack)
				hdr.ack <= 1'b0;
			if (rgn_req && rgn_ack)
				rgn_req <= 1'b0;

			if (accept) begin
				hdr.ack <= 1'b1;
				rgn_req <= 1'b1;

				// Unknown carts fall back to these
				eeprom_map        <= '0;
				bank_eeprom_quirk <= 1'b0;
				fmbusy_quirk      <= 1'b0;
				gun_type          <= 1'b0;
				gun_sensor_delay  <= gun_delay_default;

				case (hdr.serial)
					"T-081276": bank_eeprom_quirk <= 1'b1;
					"T-50446 ": eeprom_map <= 3'd1;
					"MK-1215 ": eeprom_map <= 3'd2;
					"T-81033 ": eeprom_map <= 3'd3;
					"T-35036 ": fmbusy_quirk <= 1'b1;  // FM busy flag expected
					"T-95096-": begin
						gun_type         <= 1'b1;          // Second gun type
						gun_sensor_delay <= 8'd52;
					end
					"MK-1533 ": begin
						gun_type         <= 1'b0;
						gun_sensor_delay <= 8'd100;
					end
					default: ;
				endcase
			end
		end
	end

	// Flags held for the region handshake
	always_ff @(posedge clk_sys) begin
		if (accept)
			rgn_flags <= hdr.flags;
	end

endmodule

// File: src/region_select.sv
// Third pipeline stage that resolves the console region from header flags and a priority order
`timescale 1ns/10ps

module region_select (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    rgn_req,
	output logic                    rgn_ack,
	input  cart_pkg::region_flags_t rgn_flags,
	input  logic                    auto_region,
	input  cart_pkg::prio_e         region_prio,
	output cart_pkg::region_e       region,
	output logic                    region_set
);
	import cart_pkg::*;

	region_e pick;

	// First named market in search order or else the order's default
	always_comb begin
		case (region_prio)
			prio_uej: if (rgn_flags.u) pick = us;
				else if (rgn_flags.e) pick = eu;
				else if (rgn_flags.j) pick = jp;
				else pick = us;
			prio_euj: if (rgn_flags.e) pick = eu;
				else if (rgn_flags.u) pick = us;
				else if (rgn_flags.j) pick = jp;
				else pick = eu;
			prio_uje: if (rgn_flags.u) pick = us;
				else if (rgn_flags.j) pick = jp;
				else if (rgn_flags.e) pick = eu;
				else pick = us;
			default: if (rgn_flags.j) pick = jp;
				else if (rgn_flags.u) pick = us;
				else if (rgn_flags.e) pick = eu;
				else pick = jp;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rgn_ack    <= 1'b0;
			region     <= jp;
			region_set <= 1'b0;
		end else begin
			rgn_ack    <= rgn_req;   // Ack follows req by one cycle
			region_set <= 1'b0;
			if (rgn_req && !rgn_ack && auto_region) begin
				region     <= pick;
				region_set <= 1'b1;   // Single-cycle strobe
			end
		end
	end

endmodule

// File: src/cart_loader_top.sv
// Top level of the cartridge header pipeline that chains capture, classify and region select
`timescale 1ns/10ps

module cart_loader_top (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  dl_active,
	input  logic                  dl_wr,
	input  cart_pkg::dl_addr_t    dl_addr,
	input  cart_pkg::dl_data_t    dl_data,
	input  logic                  auto_region,
	input  cart_pkg::prio_e       region_prio,
	output cart_pkg::region_e     region,
	output logic                  region_set,
	output cart_pkg::dl_addr_t    rom_size,
	output cart_pkg::eeprom_map_t eeprom_map,
	output logic                  bank_eeprom_quirk,
	output logic                  fmbusy_quirk,
	output logic                  gun_type,
	output logic [7:0]            gun_sensor_delay
);
	import cart_pkg::*;

	// Classify to region select link
	logic          rgn_req;
	logic          rgn_ack;
	region_flags_t rgn_flags;

	hdr_if hdr ();   // Capture to classify link

	header_capture u_capture (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.hdr       (hdr.src),
		.rom_size  (rom_size)
	);

	cart_classify u_classify (
		.clk_sys           (clk_sys),
		.RESET             (RESET),
		.hdr               (hdr.dst),
		.rgn_req           (rgn_req),
		.rgn_ack           (rgn_ack),
		.rgn_flags         (rgn_flags),
		.eeprom_map        (eeprom_map),
		.bank_eeprom_quirk (bank_eeprom_quirk),
		.fmbusy_quirk      (fmbusy_quirk),
		.gun_type          (gun_type),
		.gun_sensor_delay  (gun_sensor_delay)
	);

	region_select u_region (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.rgn_req     (rgn_req),
		.rgn_ack     (rgn_ack),
		.rgn_flags   (rgn_flags),
		.auto_region (auto_region),
		.region_prio (region_prio),
		.region      (region),
		.region_set  (region_set)
	);

endmodule

// File: test/cart_loader_asserts.sv
// Handshake and region output assertions, bound into the pipeline top level for simulation
`timescale 1ns/10ps

module cart_loader_asserts (
	input logic       clk_sys,
	input logic       RESET,
	input logic       hdr_req,
	input logic       hdr_ack,
	input logic       rgn_req,
	input logic       rgn_ack,
	input logic       region_set,
	input logic [1:0] region
);

	hdr_req_held: assert property (@(posedge clk_sys) disable iff (RESET)
		hdr_req && !hdr_ack |=> hdr_req)
		else $error("hdr req dropped before ack");

	rgn_req_held: assert property (@(posedge clk_sys) disable iff (RESET)
		rgn_req && !rgn_ack |=> rgn_req)
		else $error("rgn_req dropped before rgn_ack");

	// Strobe is one cycle wide
	set_single: assert property (@(posedge clk_sys) disable iff (RESET)
		region_set |=> !region_set)
		else $error("region_set high for two cycles");

	region_legal: assert property (@(posedge clk_sys) disable iff (RESET)
		region != 2'd3)
		else $error("region holds the unused code 3");

endmodule

bind cart_loader_top cart_loader_asserts u_asserts (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.hdr_req    (hdr.req),
	.hdr_ack    (hdr.ack),
	.rgn_req    (rgn_req),
	.rgn_ack    (rgn_ack),
	.region_set (region_set),
	.region     (region)
);

// File: test/tb_cart_loader.sv
// Directed testbench for the cartridge header pipeline; built and run by the Makefile sim target
`timescale 1ns/10ps

module tb_cart_loader;
	import cart_pkg::*;

	localparam int region_timeout = 8;   // Cycles allowed from download end to region_set

	logic        clk_sys;
	logic        RESET;
	logic        dl_active;
	logic        dl_wr;
	dl_addr_t    dl_addr;
	dl_data_t    dl_data;
	logic        auto_region;
	prio_e       region_prio;
	region_e     region;
	logic        region_set;
	dl_addr_t    rom_size;
	eeprom_map_t eeprom_map;
	logic        bank_eeprom_quirk;
	logic        fmbusy_quirk;
	logic        gun_type;
	logic [7:0]  gun_sensor_delay;
	int          check_count;
	int          error_count;
	int          set_count;   // region_set pulses seen

	cart_loader_top u_cart_loader_top (
		.clk_sys           (clk_sys),
		.RESET             (RESET),
		.dl_active         (dl_active),
		.dl_wr             (dl_wr),
		.dl_addr           (dl_addr),
		.dl_data           (dl_data),
		.auto_region       (auto_region),
		.region_prio       (region_prio),
		.region            (region),
		.region_set        (region_set),
		.rom_size          (rom_size),
		.eeprom_map        (eeprom_map),
		.bank_eeprom_quirk (bank_eeprom_quirk),
		.fmbusy_quirk      (fmbusy_quirk),
		.gun_type          (gun_type),
		.gun_sensor_delay  (gun_sensor_delay)
	);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		if (RESET)
			set_count <= 0;
		else if (region_set)
			set_count <= set_count + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (error_count == errs_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, error_count - errs_before);
	endtask

	// ROM image byte with the serial at 0x183..0x18A and region chars at 0x1F0..0x1F2
	function automatic logic [7:0] rom_byte(input dl_addr_t a, input cart_serial_t serial,
			input logic [23:0] rgn, input logic [7:0] fill);
		int k;
		if (a >= 25'h183 && a <= 25'h18A) begin
			k = int'(a - 25'h183);
			return serial[63 - 8*k -: 8];
		end
		if (a >= 25'h1F0 && a <= 25'h1F2) begin
			k = int'(a - 25'h1F0);
			return rgn[23 - 8*k -: 8];
		end
		return fill;
	endfunction

	task automatic download_rom(input cart_serial_t serial, input logic [23:0] rgn,
			input dl_addr_t last_addr);
		dl_addr_t    a;
		logic [31:0] rnd;
		a = '0;
		dl_active = 1'b1;
		while (a <= last_addr) begin
			rnd     = $urandom;
			dl_wr   = 1'b1;
			dl_addr = a;
			dl_data = {rom_byte(a + 25'd1, serial, rgn, rnd[15:8]),
				rom_byte(a, serial, rgn, rnd[7:0])};   // Even byte in the low half
			@(posedge clk_sys);
			#1;
			a = a + 25'd2;
		end
		dl_wr     = 1'b0;
		dl_active = 1'b0;
		dl_addr   = last_addr;
		@(posedge clk_sys);   // rom_size taken here
		#1;
	endtask

	task automatic wait_region_set(input int base);
		int n;
		n = 0;
		while (set_count == base && n < region_timeout) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (set_count == base) begin
			error_count++;
			$display("Timeout: region_set did not pulse within %0d cycles", region_timeout);
		end
	endtask

	// Search order per priority value whose first entry doubles as the default
	function automatic region_e expect_region(input region_flags_t f, input logic [1:0] prio);
		region_e order [3];
		case (prio)
			2'd0:    order = '{us, eu, jp};
			2'd1:    order = '{eu, us, jp};
			2'd2:    order = '{us, jp, eu};
			default: order = '{jp, us, eu};
		endcase
		for (int i = 0; i < 3; i++) begin
			if ((order[i] == jp && f.j) || (order[i] == us && f.u) || (order[i] == eu && f.e))
				return order[i];
		end
		return order[0];
	endfunction

	// Numeric code with j from bit 0, u from bit 2 and e from bit 3
	function automatic region_flags_t code_flags(input logic [7:0] c);
		logic [3:0] v;
		v = c[3:0];
		if (c >= "A" && c <= "F")
			v = 4'(c - "A" + 10);
		return {v[0], v[2], v[3]};
	endfunction

	task automatic region_case(input logic [23:0] rgn, input region_flags_t f,
			input logic [1:0] prio);
		int base;
		region_prio = prio_e'(prio);
		base = set_count;
		download_rom("NO-SUCH ", rgn, 25'h200);
		wait_region_set(base);
		check("region", 32'(region), 32'(expect_region(f, prio)));
	endtask

	task automatic quirk_case(input cart_serial_t serial, input logic [2:0] map,
			input logic bank, input logic fm, input logic gun, input logic [7:0] delay);
		int base;
		base = set_count;
		download_rom(serial, "U  ", 25'h200);
		wait_region_set(base);
		check("eeprom_map", 32'(eeprom_map), 32'(map));
		check("bank_eeprom_quirk", 32'(bank_eeprom_quirk), 32'(bank));
		check("fmbusy_quirk", 32'(fmbusy_quirk), 32'(fm));
		check("gun_type", 32'(gun_type), 32'(gun));
		check("gun_sensor_delay", 32'(gun_sensor_delay), 32'(delay));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic letter_region_orders();
		int errs;
		errs = error_count;
		for (int p = 0; p < 4; p++) begin
			region_case("J  ", 3'b100, p[1:0]);   // Flag bits j u e
			region_case("UE ", 3'b011, p[1:0]);
			region_case("JUE", 3'b111, p[1:0]);
			region_case("   ", 3'b000, p[1:0]);
		end
		report_test("letter region", errs);
	endtask

	task automatic numeric_region_codes();
		int         errs;
		logic [7:0] codes [4];
		codes = '{"1", "4", "8", "D"};
		errs = error_count;
		for (int i = 0; i < 4; i++)
			region_case({codes[i], "  "}, code_flags(codes[i]), 2'd0);
		report_test("numeric region", errs);
	endtask

	task automatic quirk_lookup();
		int errs;
		errs = error_count;
		region_prio = prio_uej;
		quirk_case("T-081276", 3'd0, 1'b1, 1'b0, 1'b0, 8'd44);
		quirk_case("T-50446 ", 3'd1, 1'b0, 1'b0, 1'b0, 8'd44);
		quirk_case("MK-1215 ", 3'd2, 1'b0, 1'b0, 1'b0, 8'd44);
		quirk_case("T-81033 ", 3'd3, 1'b0, 1'b0, 1'b0, 8'd44);
		quirk_case("T-35036 ", 3'd0, 1'b0, 1'b1, 1'b0, 8'd44);
		quirk_case("T-95096-", 3'd0, 1'b0, 1'b0, 1'b1, 8'd52);
		quirk_case("SEGA-XX ", 3'd0, 1'b0, 1'b0, 1'b0, 8'd44);   // Back to defaults
		quirk_case("MK-1533 ", 3'd0, 1'b0, 1'b0, 1'b0, 8'd100);
		quirk_case("SEGA-XX ", 3'd0, 1'b0, 1'b0, 1'b0, 8'd44);
		report_test("quirk lookup", errs);
	endtask

	task automatic auto_region_off();
		int errs;
		int base;
		errs = error_count;
		region_case("J  ", 3'b100, 2'd3);   // Start from jp
		auto_region = 1'b0;
		region_prio = prio_uej;
		base = set_count;
		download_rom("T-35036 ", "U  ", 25'h200);
		for (int i = 0; i < 20; i++) begin
			@(posedge clk_sys);
			#1;
		end
		check("region_set pulses", set_count, base);
		check("region held", 32'(region), 32'(jp));
		check("fmbusy_quirk", 32'(fmbusy_quirk), 32'd1);
		auto_region = 1'b1;
		report_test("auto region off", errs);
	endtask

	task automatic rom_size_latch();
		int       errs;
		int       base;
		dl_addr_t sizes [2];
		sizes = '{25'h2A4, 25'h41E};
		errs = error_count;
		for (int i = 0; i < 2; i++) begin
			base = set_count;
			download_rom("NO-SUCH ", "E  ", sizes[i]);
			check("rom_size", 32'(rom_size), 32'(sizes[i]));
			wait_region_set(base);
		end
		report_test("rom size", errs);
	endtask

	initial begin
		void'($urandom(32'h28f3));
		$timeformat(-9, 0, " ns", 0);
		clk_sys     = 1'b0;
		RESET       = 1'b1;
		dl_active   = 1'b0;
		dl_wr       = 1'b0;
		dl_addr     = '0;
		dl_data     = '0;
		auto_region = 1'b1;
		region_prio = prio_uej;
		check_count = 0;
		error_count = 0;
		for (int i = 0; i < 8; i++)
			@(posedge clk_sys);
		#1;
		RESET = 1'b0;

		letter_region_orders();
		numeric_region_codes();
		quirk_lookup();
		auto_region_off();
		rom_size_latch();

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: sources.f
src/cart_pkg.sv
src/hdr_if.sv
src/header_capture.sv
src/cart_classify.sv
src/region_select.sv
src/cart_loader_top.sv
test/cart_loader_asserts.sv
test/tb_cart_loader.sv

// File: Makefile
TOP = tb_cart_loader

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sources.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
